//--- vector_params.svh
`ifndef VECTOR_PARAMS_SVH
`define VECTOR_PARAMS_SVH

// register file geometry.
`define VU_NUM_VREGS       32
`define VU_VREG_ADDR_W     5
`define VU_LANES           4
`define VU_ELEN            8
`define VU_VLEN            32

// apb address map.
`define VU_APB_ADDR_W      12
`define VU_ADDR_INSTR      12'h000
`define VU_ADDR_SCALAR     12'h004
// bit 0 is the sticky illegal flag and any write clears it.
`define VU_ADDR_STATUS     12'h008
// register n sits at base + 4n.
`define VU_ADDR_VREG_BASE  12'h100

`endif

//--- vec_isa_pkg.sv
`default_nettype none

package vec_isa_pkg;

    localparam logic [6:0] OPCODE_OPV = 7'b1010111;

    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPCFG = 3'b111
    } funct3_e;

    typedef enum logic [5:0] {
        F6_VADD = 6'b000000,
        F6_VSUB = 6'b000010,
        F6_VAND = 6'b001001,
        F6_VOR  = 6'b001010,
        F6_VXOR = 6'b001011,
        F6_VMUL = 6'b100101
    } funct6_e;

    // bits 19:15 are vs1/rs1 in the register forms and simm5 in the immediate form.
    typedef union packed {
        struct packed {
            funct6_e    funct6;
            logic       vm;
            logic [4:0] vs2;
            logic [4:0] vs1;
            funct3_e    funct3;
            logic [4:0] vd;
            logic [6:0] opcode;
        } vreg_form;
        struct packed {
            funct6_e    funct6;
            logic       vm;
            logic [4:0] vs2;
            logic [4:0] simm5;
            funct3_e    funct3;
            logic [4:0] vd;
            logic [6:0] opcode;
        } vimm_form;
    } vinstr_t;

endpackage

`default_nettype wire

//--- vec_exec_pkg.sv
`default_nettype none

package vec_exec_pkg;

    // bit 0 set selects the broadcast scalar or immediate as second operand.
    typedef enum logic [3:0] {
        VOP_ADD_VV = 4'b0000,
        VOP_ADD_VX = 4'b0001,
        VOP_SUB_VV = 4'b0010,
        VOP_SUB_VX = 4'b0011,
        VOP_MUL_VV = 4'b0100,
        VOP_MUL_VX = 4'b0101,
        VOP_AND_VV = 4'b0110,
        VOP_AND_VX = 4'b0111,
        VOP_OR_VV  = 4'b1000,
        VOP_OR_VX  = 4'b1001,
        VOP_XOR_VV = 4'b1010,
        VOP_XOR_VX = 4'b1011,
        VOP_NOP    = 4'b1111
    } valu_op_e;

    typedef enum logic {
        SRC_REG = 1'b0,
        SRC_IMM = 1'b1
    } valu_src_e;

endpackage

`default_nettype wire

//--- vcontrol_unit.sv
`timescale 1ns/1ns
`default_nettype none

module vcontrol_unit (
    input  wire logic [6:0]             opcode,
    input  wire vec_isa_pkg::funct3_e   funct3,
    input  wire vec_isa_pkg::funct6_e   funct6,
    output logic                        vreg_write,
    output vec_exec_pkg::valu_op_e      valu_op,
    output vec_exec_pkg::valu_src_e     valu_src,
    output logic                        illegal
);

    vec_exec_pkg::valu_op_e op_vv;
    logic                   known_f6;

    // op_vv holds the register form encoding and the broadcast form sets bit 0.
    always_comb begin
        known_f6 = 1'b1;
        op_vv    = vec_exec_pkg::VOP_NOP;
        case (funct6)
            vec_isa_pkg::F6_VADD: op_vv = vec_exec_pkg::VOP_ADD_VV;
            vec_isa_pkg::F6_VSUB: op_vv = vec_exec_pkg::VOP_SUB_VV;
            vec_isa_pkg::F6_VMUL: op_vv = vec_exec_pkg::VOP_MUL_VV;
            vec_isa_pkg::F6_VAND: op_vv = vec_exec_pkg::VOP_AND_VV;
            vec_isa_pkg::F6_VOR:  op_vv = vec_exec_pkg::VOP_OR_VV;
            vec_isa_pkg::F6_VXOR: op_vv = vec_exec_pkg::VOP_XOR_VV;
            default:              known_f6 = 1'b0;
        endcase
    end

    always_comb begin
        vreg_write = 1'b0;
        valu_op    = vec_exec_pkg::VOP_NOP;
        valu_src   = vec_exec_pkg::SRC_REG;
        illegal    = 1'b1;
        if (opcode == vec_isa_pkg::OPCODE_OPV) begin
            case (funct3)
                vec_isa_pkg::OPIVV: begin
                    if (known_f6) begin
                        vreg_write = 1'b1;
                        valu_op    = op_vv;
                        illegal    = 1'b0;
                    end
                end
                vec_isa_pkg::OPIVX, vec_isa_pkg::OPIVI: begin
                    if (funct3 == vec_isa_pkg::OPIVI) begin
                        valu_src = vec_exec_pkg::SRC_IMM;
                    end
                    if (known_f6) begin
                        vreg_write = 1'b1;
                        valu_op    = vec_exec_pkg::valu_op_e'({op_vv[3:1], 1'b1});
                        illegal    = 1'b0;
                    end
                end
                // vector length is fixed, so configuration is a no-op.
                vec_isa_pkg::OPCFG: begin
                    illegal = 1'b0;
                end
                default: begin
                    illegal = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- vector_regfile.sv
`timescale 1ns/1ns
`include "vector_params.svh"
`default_nettype none

module vector_regfile (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [`VU_VREG_ADDR_W-1:0]    rs_a,
    input  wire logic [`VU_VREG_ADDR_W-1:0]    rs_b,
    input  wire logic                          issue,
    input  wire logic                          wr_en,
    input  wire logic [`VU_VREG_ADDR_W-1:0]    wr_addr,
    input  wire logic [`VU_VLEN-1:0]           wr_data,
    input  wire logic [`VU_VREG_ADDR_W-1:0]    host_addr,
    input  wire logic                          host_we,
    input  wire logic [`VU_VLEN-1:0]           host_wdata,
    output logic [`VU_VLEN-1:0]                rd_a,
    output logic [`VU_VLEN-1:0]                rd_b,
    output logic [`VU_VLEN-1:0]                host_rdata
);

    logic [`VU_VLEN-1:0] vregs [`VU_NUM_VREGS];
    logic                exec_we;

    // decoder enable only counts in the execute cycle.
    assign exec_we = wr_en & issue;

    // host is stalled while an instruction executes, so the ports never collide.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `VU_NUM_VREGS; i++) begin
                vregs[i] <= '0;
            end
        end else if (exec_we) begin
            vregs[wr_addr] <= wr_data;
        end else if (host_we) begin
            vregs[host_addr] <= host_wdata;
        end
    end

    assign rd_a       = vregs[rs_a];
    assign rd_b       = vregs[rs_b];
    assign host_rdata = vregs[host_addr];

endmodule

`default_nettype wire

//--- vector_alu.sv
`timescale 1ns/1ns
`include "vector_params.svh"
`default_nettype none

module vector_alu (
    input  wire logic [`VU_VLEN-1:0]       op_a,
    input  wire logic [`VU_VLEN-1:0]       op_b,
    input  wire logic [`VU_VLEN-1:0]       scalar,
    input  wire logic [4:0]                simm5,
    input  wire vec_exec_pkg::valu_op_e    valu_op,
    input  wire vec_exec_pkg::valu_src_e   valu_src,
    output logic [`VU_VLEN-1:0]            result
);

    localparam int ELEN  = `VU_ELEN;
    localparam int LANES = `VU_LANES;

    logic [ELEN-1:0] bcast;
    logic [ELEN-1:0] lane_a;
    logic [ELEN-1:0] lane_b;
    logic [ELEN-1:0] lane_r;

    // scalar low byte or sign-extended simm5 goes to every lane.
    assign bcast = (valu_src == vec_exec_pkg::SRC_IMM) ?
                   {{(ELEN-5){simm5[4]}}, simm5} : scalar[ELEN-1:0];

    always_comb begin
        result = '0;
        lane_a = '0;
        lane_b = '0;
        lane_r = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_a = op_a[i*ELEN +: ELEN];
            lane_b = valu_op[0] ? bcast : op_b[i*ELEN +: ELEN];
            // all results wrap modulo 2^ELEN.
            case (valu_op)
                vec_exec_pkg::VOP_ADD_VV, vec_exec_pkg::VOP_ADD_VX: lane_r = lane_a + lane_b;
                vec_exec_pkg::VOP_SUB_VV, vec_exec_pkg::VOP_SUB_VX: lane_r = lane_a - lane_b;
                vec_exec_pkg::VOP_MUL_VV, vec_exec_pkg::VOP_MUL_VX: lane_r = lane_a * lane_b;
                vec_exec_pkg::VOP_AND_VV, vec_exec_pkg::VOP_AND_VX: lane_r = lane_a & lane_b;
                vec_exec_pkg::VOP_OR_VV,  vec_exec_pkg::VOP_OR_VX:  lane_r = lane_a | lane_b;
                vec_exec_pkg::VOP_XOR_VV, vec_exec_pkg::VOP_XOR_VX: lane_r = lane_a ^ lane_b;
                default:                                            lane_r = '0;
            endcase
            result[i*ELEN +: ELEN] = lane_r;
        end
    end

endmodule

`default_nettype wire

//--- vector_apb_regs.sv
`timescale 1ns/1ns
`include "vector_params.svh"
`default_nettype none

module vector_apb_regs (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          psel,
    input  wire logic                          penable,
    input  wire logic                          pwrite,
    input  wire logic [`VU_APB_ADDR_W-1:0]     paddr,
    input  wire logic [31:0]                   pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  wire logic                          illegal,
    input  wire logic [`VU_VLEN-1:0]           vreg_rdata,
    output vec_isa_pkg::funct3_e               funct3,
    output vec_isa_pkg::funct6_e               funct6,
    output logic [6:0]                         opcode,
    output logic [`VU_VREG_ADDR_W-1:0]         vs1,
    output logic [`VU_VREG_ADDR_W-1:0]         vs2,
    output logic [`VU_VREG_ADDR_W-1:0]         vd,
    output logic [4:0]                         simm5,
    output logic [`VU_VLEN-1:0]                scalar,
    output logic [`VU_VREG_ADDR_W-1:0]         vreg_addr,
    output logic                               vreg_we,
    output logic [`VU_VLEN-1:0]                vreg_wdata,
    output logic                               issue
);

    vec_isa_pkg::vinstr_t instr_q;
    logic                 busy;
    logic                 illegal_flag;
    logic                 access;
    logic                 sel_instr;
    logic                 sel_scalar;
    logic                 sel_status;
    logic                 sel_vreg;
    logic                 start;
    logic                 wr_done;

    assign access     = psel & penable;
    assign sel_instr  = (paddr == `VU_ADDR_INSTR);
    assign sel_scalar = (paddr == `VU_ADDR_SCALAR);
    assign sel_status = (paddr == `VU_ADDR_STATUS);
    assign sel_vreg   = (paddr >= `VU_ADDR_VREG_BASE) &&
                        (paddr < `VU_ADDR_VREG_BASE + 4 * `VU_NUM_VREGS);

    // first access cycle of an instruction write becomes the wait state.
    assign start   = access & pwrite & sel_instr & ~busy;
    assign pready  = ~start;
    assign wr_done = access & pwrite & pready;
    assign pslverr = (busy & illegal) |
                     (access & ~(sel_instr | sel_scalar | sel_status | sel_vreg));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_q      <= '0;
            scalar       <= '0;
            busy         <= 1'b0;
            illegal_flag <= 1'b0;
        end else begin
            busy <= start;
            if (start) begin
                instr_q <= pwdata;
            end
            if (wr_done && sel_scalar) begin
                scalar <= pwdata;
            end
            if (wr_done && sel_status) begin
                illegal_flag <= 1'b0;
            end else if (busy && illegal) begin
                illegal_flag <= 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (sel_instr)       prdata = instr_q;
        else if (sel_scalar) prdata = scalar;
        else if (sel_status) prdata = {31'b0, illegal_flag};
        else if (sel_vreg)   prdata = vreg_rdata;
    end

    assign issue      = busy;
    assign vreg_addr  = paddr[`VU_VREG_ADDR_W+1:2];
    assign vreg_we    = wr_done & sel_vreg;
    assign vreg_wdata = pwdata;

    assign opcode = instr_q.vreg_form.opcode;
    assign funct3 = instr_q.vreg_form.funct3;
    assign funct6 = instr_q.vreg_form.funct6;
    assign vd     = instr_q.vreg_form.vd;
    assign vs2    = instr_q.vreg_form.vs2;
    assign vs1    = instr_q.vreg_form.vs1;
    assign simm5  = instr_q.vimm_form.simm5;

endmodule

`default_nettype wire

//--- vector_unit.sv
`timescale 1ns/1ns
`include "vector_params.svh"
`default_nettype none

module vector_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          psel,
    input  wire logic                          penable,
    input  wire logic                          pwrite,
    input  wire logic [`VU_APB_ADDR_W-1:0]     paddr,
    input  wire logic [31:0]                   pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr
);

    vec_isa_pkg::funct3_e              funct3;
    vec_isa_pkg::funct6_e              funct6;
    logic [6:0]                        opcode;
    logic [`VU_VREG_ADDR_W-1:0]        vs1;
    logic [`VU_VREG_ADDR_W-1:0]        vs2;
    logic [`VU_VREG_ADDR_W-1:0]        vd;
    logic [4:0]                        simm5;
    logic [`VU_VLEN-1:0]               scalar;
    logic [`VU_VREG_ADDR_W-1:0]        vreg_addr;
    logic                              vreg_we;
    logic [`VU_VLEN-1:0]               vreg_wdata;
    logic [`VU_VLEN-1:0]               vreg_rdata;
    logic                              issue;
    logic                              vreg_write;
    vec_exec_pkg::valu_op_e            valu_op;
    vec_exec_pkg::valu_src_e           valu_src;
    logic                              illegal;
    logic [`VU_VLEN-1:0]               rd_a;
    logic [`VU_VLEN-1:0]               rd_b;
    logic [`VU_VLEN-1:0]               alu_result;

    vector_apb_regs apb_regs_inst (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .illegal(illegal), .vreg_rdata(vreg_rdata),
        .funct3(funct3), .funct6(funct6), .opcode(opcode), .vs1(vs1), .vs2(vs2),
        .vd(vd), .simm5(simm5), .scalar(scalar), .vreg_addr(vreg_addr),
        .vreg_we(vreg_we), .vreg_wdata(vreg_wdata), .issue(issue)
    );

    vcontrol_unit vcontrol_unit_inst (
        .opcode(opcode), .funct3(funct3), .funct6(funct6), .vreg_write(vreg_write),
        .valu_op(valu_op), .valu_src(valu_src), .illegal(illegal)
    );

    // vs2 is the first operand, vs1 the second.
    vector_regfile vector_regfile_inst (
        .clk(clk), .rst_n(rst_n), .rs_a(vs2), .rs_b(vs1), .issue(issue),
        .wr_en(vreg_write), .wr_addr(vd), .wr_data(alu_result),
        .host_addr(vreg_addr), .host_we(vreg_we), .host_wdata(vreg_wdata),
        .rd_a(rd_a), .rd_b(rd_b), .host_rdata(vreg_rdata)
    );

    vector_alu vector_alu_inst (
        .op_a(rd_a), .op_b(rd_b), .scalar(scalar), .simm5(simm5),
        .valu_op(valu_op), .valu_src(valu_src), .result(alu_result)
    );

endmodule

`default_nettype wire

//--- vector_unit_chk.sv
`timescale 1ns/1ns
`include "vector_params.svh"
`default_nettype none

module vector_unit_chk (
    input wire logic                          clk,
    input wire logic                          rst_n,
    input wire logic                          psel,
    input wire logic                          penable,
    input wire logic                          pwrite,
    input wire logic [`VU_APB_ADDR_W-1:0]     paddr,
    input wire logic                          pready,
    input wire logic                          pslverr,
    input wire logic                          issue,
    input wire logic                          vreg_write
);

    logic instr_wr;

    assign instr_wr = psel & penable & pwrite & (paddr == `VU_ADDR_INSTR);

    // a wait state only comes with an instruction write and lasts one cycle.
    wait_source: assert property (@(posedge clk) disable iff (!rst_n)
        !pready |-> instr_wr) else $error("pready low outside an instruction write");
    wait_length: assert property (@(posedge clk) disable iff (!rst_n)
        !pready |=> pready) else $error("wait state longer than one cycle");

    // the write-back follows an instruction write and never comes with an error.
    exec_window: assert property (@(posedge clk) disable iff (!rst_n)
        (vreg_write && issue) |-> ($past(instr_wr) && pready && !pslverr))
        else $error("register write outside the execute cycle or with pslverr");

    err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> pready) else $error("pslverr without pready");

endmodule

bind vector_unit vector_unit_chk vector_unit_chk_inst (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pready(pready), .pslverr(pslverr), .issue(issue),
    .vreg_write(vreg_write)
);

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial clk = 1'b0;

    // 100 ns period.
    always #50 clk = ~clk;

endmodule

`default_nettype wire

//--- tb_vector_unit.sv
`timescale 1ns/1ns
`include "vector_params.svh"
`default_nettype none

module tb_vector_unit;

    localparam logic [6:0] OPV = 7'b1010111;
    // model order is add, sub, mul, and, or, xor.
    localparam logic [5:0] F6_CODES [6] = '{6'b000000, 6'b000010, 6'b100101,
                                             6'b001001, 6'b001010, 6'b001011};
    // vector-vector, vector-scalar, vector-immediate.
    localparam logic [2:0] F3_FORMS [3] = '{3'b000, 3'b100, 3'b011};
    localparam logic [2:0] F3_UNUSED [4] = '{3'b001, 3'b010, 3'b101, 3'b110};

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] model [32];
    logic [31:0] scalar_m;
    logic [31:0] rdata;
    logic [31:0] err;
    logic [31:0] rnd;
    logic [31:0] bvec;
    logic [31:0] expected;
    logic [4:0]  vs2;
    logic [4:0]  vs1;
    logic [4:0]  vd;
    logic [5:0]  f6;
    logic [2:0]  f3;
    logic [6:0]  opc;
    int          waits;
    int          errors;
    int          checks;
    integer      seed;

    tb_clock_gen clk_gen_inst (.clk(clk));

    vector_unit vector_unit_inst (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
        end
    endtask

    // one apb transfer, counting wait states in the access phase.
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                            output logic [31:0] rd, output logic [31:0] slverr,
                            output int wait_cnt);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        wait_cnt = 0;
        @(negedge clk);
        while (!pready) begin
            wait_cnt++;
            if (wait_cnt > 16) begin
                $display("timeout: pready stuck low on access to address %h", addr);
                $display("Test failed");
                $finish;
            end
            @(negedge clk);
        end
        rd     = prdata;
        slverr = {31'b0, pslverr};
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic [11:0] vreg_addr(input logic [4:0] idx);
        return `VU_ADDR_VREG_BASE + {5'b0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] lanes_apply(input int op, input logic [31:0] a,
                                                input logic [31:0] b);
        logic [31:0] r;
        logic [7:0]  x;
        logic [7:0]  y;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            x = a[i*8 +: 8];
            y = b[i*8 +: 8];
            case (op)
                0:       r[i*8 +: 8] = x + y;
                1:       r[i*8 +: 8] = x - y;
                2:       r[i*8 +: 8] = x * y;
                3:       r[i*8 +: 8] = x & y;
                4:       r[i*8 +: 8] = x | y;
                default: r[i*8 +: 8] = x ^ y;
            endcase
        end
        return r;
    endfunction

    task automatic scan_regs();
        logic [31:0] rd;
        logic [31:0] se;
        int          wc;
        for (int i = 0; i < 32; i++) begin
            apb_xfer(1'b0, vreg_addr(i[4:0]), 32'd0, rd, se, wc);
            check($sformatf("vreg[%0d]", i), model[i], rd);
        end
    endtask

    task automatic issue_instr(input logic [31:0] word, input logic [31:0] exp_err);
        apb_xfer(1'b1, `VU_ADDR_INSTR, word, rdata, err, waits);
        check("pslverr", exp_err, err);
        check("instr wait states", 32'd1, waits);
    endtask

    initial begin
        seed    = 32'he73a;
        errors  = 0;
        checks  = 0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("pready", 32'd1, {31'b0, pready});
        check("pslverr", 32'd0, {31'b0, pslverr});
        apb_xfer(1'b0, `VU_ADDR_STATUS, 32'd0, rdata, err, waits);
        check("status", 32'd0, rdata);
        scan_regs();

        // host writes and readback through the register window.
        for (int i = 0; i < 32; i++) begin
            model[i] = $random(seed);
            apb_xfer(1'b1, vreg_addr(i[4:0]), model[i], rdata, err, waits);
            check("pslverr", 32'd0, err);
            check("vreg write wait states", 32'd0, waits);
        end
        scan_regs();
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            apb_xfer(1'b0, 12'h200 + {2'b00, rnd[7:0], 2'b00}, 32'd0, rdata, err, waits);
            check("unmapped pslverr", 32'd1, err);
            check("unmapped prdata", 32'd0, rdata);
            check("unmapped wait states", 32'd0, waits);
        end

        // legal instructions over every operation and form.
        scalar_m = '0;
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            vs2 = rnd[4:0];
            vs1 = rnd[9:5];
            vd  = rnd[14:10];
            if ((n / 6) % 3 == 1) begin
                scalar_m = $random(seed);
                apb_xfer(1'b1, `VU_ADDR_SCALAR, scalar_m, rdata, err, waits);
                check("scalar wait states", 32'd0, waits);
            end
            case ((n / 6) % 3)
                0:       bvec = model[vs1];
                1:       bvec = {4{scalar_m[7:0]}};
                default: bvec = {4{{3{vs1[4]}}, vs1}};
            endcase
            expected = lanes_apply(n % 6, model[vs2], bvec);
            issue_instr({F6_CODES[n % 6], 1'b1, vs2, vs1, F3_FORMS[(n / 6) % 3], vd, OPV},
                        32'd0);
            model[vd] = expected;
            apb_xfer(1'b0, vreg_addr(vd), 32'd0, rdata, err, waits);
            check($sformatf("vreg[%0d]", vd), expected, rdata);
        end

        // configuration is a no-op.
        rnd = $random(seed);
        issue_instr({rnd[31:26], 1'b1, rnd[4:0], rnd[9:5], 3'b111, rnd[14:10], OPV}, 32'd0);
        scan_regs();

        // illegal encodings write nothing and set the sticky flag.
        for (int n = 0; n < 12; n++) begin
            rnd = $random(seed);
            f6  = F6_CODES[n % 6];
            f3  = 3'b000;
            opc = OPV;
            case (n % 3)
                0: begin
                    f6 = rnd[5:0];
                    for (int j = 0; j < 6; j++) begin
                        if (f6 == F6_CODES[j]) begin
                            f6 = f6 ^ 6'b010000;
                        end
                    end
                end
                1: begin
                    opc = rnd[6:0];
                    if (opc == OPV) begin
                        opc = opc ^ 7'h01;
                    end
                end
                default: f3 = F3_UNUSED[rnd[1:0]];
            endcase
            issue_instr({f6, 1'b1, rnd[12:8], rnd[17:13], f3, rnd[22:18], opc}, 32'd1);
            apb_xfer(1'b0, `VU_ADDR_STATUS, 32'd0, rdata, err, waits);
            check("status", 32'd1, rdata);
            apb_xfer(1'b1, `VU_ADDR_STATUS, rnd, rdata, err, waits);
            check("status write pslverr", 32'd0, err);
            apb_xfer(1'b0, `VU_ADDR_STATUS, 32'd0, rdata, err, waits);
            check("status", 32'd0, rdata);
        end
        scan_regs();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vector_unit.f
+incdir+.
vec_isa_pkg.sv
vec_exec_pkg.sv
vcontrol_unit.sv
vector_regfile.sv
vector_alu.sv
vector_apb_regs.sv
vector_unit.sv
vector_unit_chk.sv
tb_clock_gen.sv
tb_vector_unit.sv

//--- run.sh
#!/bin/sh
# build and run the vector unit testbench with verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vector_unit.f \
    --top-module tb_vector_unit -o tb_vector_unit

./obj_dir/tb_vector_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
